// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_bt_corr
FILELIST  = project.f
PASS_MSG  = Result: PASSED
SIM       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: bt_air_pkg.sv
package bt_air_pkg;

  // access code sync word
  localparam int SYNC_BITS = 64;
  typedef logic [SYNC_BITS-1:0] syncword_t;

  // correlator lanes
  localparam int NUM_LANES = 4;
  typedef logic [$clog2(NUM_LANES)-1:0] lane_id_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // 0..64 agreeing bits
  typedef logic [$clog2(SYNC_BITS+1)-1:0] match_cnt_t;

  // 1 us bit time at 6 MHz
  localparam int TICKS_PER_US = 6;
  typedef logic [$clog2(TICKS_PER_US)-1:0] tick_cnt_t;

  localparam lane_id_t LANE_CAC  = 2'd0;
  localparam lane_id_t LANE_DAC  = 2'd1;
  localparam lane_id_t LANE_GIAC = 2'd2;
  localparam lane_id_t LANE_DIAC = 2'd3;

  // exact match only
  localparam match_cnt_t THRESH_RESET = 7'd64;

  localparam int HIT_CNT_BITS = 16;
  typedef logic [HIT_CNT_BITS-1:0] hit_cnt_t;

endpackage

// File: bt_corr_tests.txt
# W adr data | R adr expected (hex)
# S noise lane errors expected_lane|none | C expected_count (decimal)
R 8 00000040
R 9 00000000
R 0 00000000
W 0 475ad1e6
W 1 9e8b3f2c
W 2 b85e06d4
W 3 2c7f1a93
W 4 73345e72
W 5 475c58cc
W 6 c9f2478b
W 7 d13a6e05
R 0 475ad1e6
R 1 9e8b3f2c
R 2 b85e06d4
R 5 475c58cc
R 7 d13a6e05
W 9 0000000f
R 9 0000000f
W 8 ffffffc0
R 8 00000040
W c deadbeef
R c 00000000
R f 00000000
S 20 0 0 0
S 13 1 0 1
S 31 2 0 2
S 9 3 0 3
C 4
W 8 0000003c
S 16 1 4 1
S 16 1 5 none
S 24 3 4 3
C 6
W 9 0000000b
S 12 2 0 none
C 6
W 6 b85e06d4
W 7 2c7f1a93
S 10 3 0 1
S 10 3 2 1
C 8
W 9 00000008
S 14 3 0 3
C 9
R 9 00000008
R 8 0000003c

// File: bt_corr_top.sv
`timescale 1ns/1ps

module bt_corr_top (
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 rxbit,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  bt_reg_pkg::wb_adr_t  wb_adr,
  input  bt_reg_pkg::wb_data_t wb_dat_w,
  output bt_reg_pkg::wb_data_t wb_dat_r,
  output logic                 wb_ack,
  output logic                 sync_hit_p,
  output bt_air_pkg::lane_id_t sync_lane,
  output bt_air_pkg::hit_cnt_t sync_count
);

  logic                   bit_tick;
  bt_air_pkg::syncword_t  rx_window;
  bt_air_pkg::syncword_t  ref_words [bt_air_pkg::NUM_LANES];
  bt_air_pkg::match_cnt_t threshold;
  bt_air_pkg::lane_mask_t lane_en;
  bt_air_pkg::lane_mask_t lane_hits;

  bt_rx_frontend rx_frontend_u (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .rxbit     (rxbit),
    .bit_tick  (bit_tick),
    .rx_window (rx_window)
  );

  // CAC, DAC, GIAC, DIAC
  for (genvar n = 0; n < bt_air_pkg::NUM_LANES; n++)
  begin : g_lane
    bt_sync_correlator corr_u (
      .clk_6M    (clk_6M),
      .rstz      (rstz),
      .bit_tick  (bit_tick),
      .rx_window (rx_window),
      .ref_word  (ref_words[n]),
      .threshold (threshold),
      .lane_en   (lane_en[n]),
      .lane_hit  (lane_hits[n])
    );
  end

  bt_sync_reporter reporter_u (
    .clk_6M     (clk_6M),
    .rstz       (rstz),
    .lane_hits  (lane_hits),
    .sync_hit_p (sync_hit_p),
    .sync_lane  (sync_lane),
    .sync_count (sync_count)
  );

  bt_reg_bank reg_bank_u (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .ref_words (ref_words),
    .threshold (threshold),
    .lane_en   (lane_en)
  );

endmodule

// File: bt_reg_bank.sv
`timescale 1ns/1ps

module bt_reg_bank (
  input  logic                   clk_6M,
  input  logic                   rstz,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  bt_reg_pkg::wb_adr_t    wb_adr,
  input  bt_reg_pkg::wb_data_t   wb_dat_w,
  output bt_reg_pkg::wb_data_t   wb_dat_r,
  output logic                   wb_ack,
  output bt_air_pkg::syncword_t  ref_words [bt_air_pkg::NUM_LANES],
  output bt_air_pkg::match_cnt_t threshold,
  output bt_air_pkg::lane_mask_t lane_en
);

  bt_reg_pkg::wb_adr_t  sync_off;
  logic                 sync_sel;
  logic                 sync_hi;
  bt_air_pkg::lane_id_t sel_lane;
  logic                 bus_req;
  logic                 wr_en;

  // reference word region decode
  assign sync_off = wb_adr - bt_reg_pkg::ADR_SYNC_BASE;
  assign sync_sel = (sync_off < bt_reg_pkg::wb_adr_t'(2 * bt_air_pkg::NUM_LANES));
  assign sync_hi  = sync_off[0];
  assign sel_lane = bt_air_pkg::lane_id_t'(sync_off >> 1);

  // new access only while ack is low
  assign bus_req = wb_cyc && wb_stb && !wb_ack;
  assign wr_en   = bus_req && wb_we;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      wb_ack <= 1'b0;
    else
      wb_ack <= bus_req;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      for (int n = 0; n < bt_air_pkg::NUM_LANES; n++)
      begin
        ref_words[n] <= '0;
      end
      threshold <= bt_air_pkg::THRESH_RESET;
      lane_en   <= '0;
    end
    else if (wr_en)
    begin
      if (sync_sel)
      begin
        if (sync_hi)
          ref_words[sel_lane][bt_reg_pkg::WB_DATA_BITS +: bt_reg_pkg::WB_DATA_BITS] <= wb_dat_w;
        else
          ref_words[sel_lane][0 +: bt_reg_pkg::WB_DATA_BITS] <= wb_dat_w;
      end
      else if (wb_adr == bt_reg_pkg::ADR_THRESH)
        threshold <= wb_dat_w[$bits(bt_air_pkg::match_cnt_t)-1:0];
      else if (wb_adr == bt_reg_pkg::ADR_LANE_EN)
        lane_en <= wb_dat_w[bt_air_pkg::NUM_LANES-1:0];
    end
  end

  // unmapped reads give 0
  always_comb
  begin
    wb_dat_r = '0;
    if (sync_sel)
    begin
      if (sync_hi)
        wb_dat_r = ref_words[sel_lane][bt_reg_pkg::WB_DATA_BITS +: bt_reg_pkg::WB_DATA_BITS];
      else
        wb_dat_r = ref_words[sel_lane][0 +: bt_reg_pkg::WB_DATA_BITS];
    end
    else if (wb_adr == bt_reg_pkg::ADR_THRESH)
      wb_dat_r = bt_reg_pkg::wb_data_t'(threshold);
    else if (wb_adr == bt_reg_pkg::ADR_LANE_EN)
      wb_dat_r = bt_reg_pkg::wb_data_t'(lane_en);
  end

endmodule

// File: bt_reg_pkg.sv
package bt_reg_pkg;

  localparam int WB_ADR_BITS  = 4;
  localparam int WB_DATA_BITS = 32;

  typedef logic [WB_ADR_BITS-1:0]  wb_adr_t;
  typedef logic [WB_DATA_BITS-1:0] wb_data_t;

  // reference words, lane n low half at 2n, high half at 2n+1
  localparam wb_adr_t ADR_SYNC_BASE = 4'd0;

  // match threshold, bits 6:0
  localparam wb_adr_t ADR_THRESH = 4'd8;

  // lane enables, bits 3:0
  localparam wb_adr_t ADR_LANE_EN = 4'd9;

endpackage

// File: bt_rx_frontend.sv
`timescale 1ns/1ps

module bt_rx_frontend (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  rxbit,
  output logic                  bit_tick,
  output bt_air_pkg::syncword_t rx_window
);

  bt_air_pkg::tick_cnt_t tick_cnt;
  logic [1:0]            rxbit_as;

  // 1 us tick, last phase of the count
  assign bit_tick = (tick_cnt == bt_air_pkg::tick_cnt_t'(bt_air_pkg::TICKS_PER_US - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      tick_cnt <= '0;
    else if (bit_tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  // two-flop resync of the air bit
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rxbit_as <= 2'b00;
    else
      rxbit_as <= {rxbit_as[0], rxbit};
  end

  // oldest bit ends up in the msb
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_window <= '0;
    else if (bit_tick)
      rx_window <= {rx_window[bt_air_pkg::SYNC_BITS-2:0], rxbit_as[1]};
  end

endmodule

// File: bt_sync_correlator.sv
`timescale 1ns/1ps

module bt_sync_correlator (
  input  logic                   clk_6M,
  input  logic                   rstz,
  input  logic                   bit_tick,
  input  bt_air_pkg::syncword_t  rx_window,
  input  bt_air_pkg::syncword_t  ref_word,
  input  bt_air_pkg::match_cnt_t threshold,
  input  logic                   lane_en,
  output logic                   lane_hit
);

  bt_air_pkg::syncword_t  agree;
  bt_air_pkg::match_cnt_t match_cnt;
  logic                   tick_d;

  assign agree = ~(rx_window ^ ref_word);

  // popcount of agreeing positions
  always_comb
  begin
    match_cnt = '0;
    for (int i = 0; i < bt_air_pkg::SYNC_BITS; i++)
    begin
      match_cnt = match_cnt + bt_air_pkg::match_cnt_t'(agree[i]);
    end
  end

  // window moves on the tick edge, judge it one cycle later
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tick_d   <= 1'b0;
      lane_hit <= 1'b0;
    end
    else
    begin
      tick_d   <= bit_tick;
      lane_hit <= tick_d && lane_en && (match_cnt >= threshold);
    end
  end

endmodule

// File: bt_sync_reporter.sv
`timescale 1ns/1ps

module bt_sync_reporter (
  input  logic                   clk_6M,
  input  logic                   rstz,
  input  bt_air_pkg::lane_mask_t lane_hits,
  output logic                   sync_hit_p,
  output bt_air_pkg::lane_id_t   sync_lane,
  output bt_air_pkg::hit_cnt_t   sync_count
);

  logic any_hit;

  assign any_hit = |lane_hits;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      sync_hit_p <= 1'b0;
      sync_count <= '0;
    end
    else
    begin
      sync_hit_p <= any_hit;
      // saturate, never wrap
      if (any_hit && (sync_count != '1))
        sync_count <= sync_count + 1'b1;
    end
  end

  // lowest lane wins
  always_ff @(posedge clk_6M)
  begin
    if (any_hit)
    begin
      if (lane_hits[bt_air_pkg::LANE_CAC])
        sync_lane <= bt_air_pkg::LANE_CAC;
      else if (lane_hits[bt_air_pkg::LANE_DAC])
        sync_lane <= bt_air_pkg::LANE_DAC;
      else if (lane_hits[bt_air_pkg::LANE_GIAC])
        sync_lane <= bt_air_pkg::LANE_GIAC;
      else
        sync_lane <= bt_air_pkg::LANE_DIAC;
    end
  end

endmodule

// File: project.f
bt_air_pkg.sv
bt_reg_pkg.sv
bt_rx_frontend.sv
bt_sync_correlator.sv
bt_sync_reporter.sv
bt_reg_bank.sv
bt_corr_top.sv
tb_bt_corr.sv

// File: tb_bt_corr.sv
`timescale 1ns/1ps

module tb_bt_corr;

  localparam int ACK_WAIT = 16;

  logic                  clk_6M;
  logic                  rstz;
  logic                  rxbit;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  bt_reg_pkg::wb_adr_t   wb_adr;
  bt_reg_pkg::wb_data_t  wb_dat_w;
  bt_reg_pkg::wb_data_t  wb_dat_r;
  logic                  wb_ack;
  logic                  sync_hit_p;
  bt_air_pkg::lane_id_t  sync_lane;
  bt_air_pkg::hit_cnt_t  sync_count;

  // one entry per test line
  byte                   op_q [$];
  int                    a_q [$];
  int                    b_q [$];
  int                    c_q [$];
  int                    d_q [$];

  bt_air_pkg::syncword_t lane_words [bt_air_pkg::NUM_LANES];
  logic [31:0]           lfsr_state;
  int                    edge_cnt;
  int                    cycle_limit;
  int                    value_errs;
  int                    proto_errs;
  logic                  watch;
  int                    hit_cnt;
  bt_air_pkg::lane_id_t  hit_lane;
  logic                  ack_seen;
  bt_reg_pkg::wb_data_t  rdata_seen;
  bt_air_pkg::hit_cnt_t  count_seen;

  bt_corr_top DUT (
    .clk_6M     (clk_6M),
    .rstz       (rstz),
    .rxbit      (rxbit),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .sync_hit_p (sync_hit_p),
    .sync_lane  (sync_lane),
    .sync_count (sync_count)
  );

  always #20 clk_6M = ~clk_6M;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    return lfsr_state[0];
  endfunction

  // outputs sampled mid cycle, then on to the next rising edge
  task automatic step();
    @(negedge clk_6M);
    ack_seen   = wb_ack;
    rdata_seen = wb_dat_r;
    count_seen = sync_count;
    if (watch && sync_hit_p)
    begin
      hit_cnt++;
      hit_lane = sync_lane;
    end
    @(posedge clk_6M);
    edge_cnt++;
  endtask

  task automatic check_data(input bt_reg_pkg::wb_data_t got, input bt_reg_pkg::wb_data_t exp,
                            input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_lane(input bt_air_pkg::lane_id_t got, input bt_air_pkg::lane_id_t exp,
                            input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s: got lane %0d, expected lane %0d", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_count(input bt_air_pkg::hit_cnt_t got, input bt_air_pkg::hit_cnt_t exp,
                             input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
      value_errs++;
    end
  endtask

  // wishbone classic, one access
  task automatic bus_access(input logic we, input bt_reg_pkg::wb_adr_t adr,
                            input bt_reg_pkg::wb_data_t wdata,
                            output bt_reg_pkg::wb_data_t rdata, output logic acked);
    int waited;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    acked  = 1'b0;
    rdata  = '0;
    waited = 0;
    while (!acked && waited < ACK_WAIT)
    begin
      step();
      waited++;
      acked = ack_seen;
      rdata = rdata_seen;
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!acked)
    begin
      $display("no ack from the DUT for the access to address %0d", adr);
      proto_errs++;
    end
    else
    begin
      step();
      if (ack_seen)
      begin
        $display("ack stayed high a second cycle at address %0d", adr);
        proto_errs++;
      end
    end
  endtask

  // one bit per 6-clock slot, slots start one edge after the tick edge
  task automatic send_bit(input logic b);
    while (edge_cnt % bt_air_pkg::TICKS_PER_US != 1)
      step();
    rxbit <= b;
    step();
  endtask

  task automatic run_stream(input int idx, input int noise, input int lane, input int nerr,
                            input int exp_lane);
    bt_air_pkg::syncword_t word;
    bt_air_pkg::syncword_t flips;
    int                    flipped;
    int                    pos;
    flips   = '0;
    flipped = 0;
    while (flipped < nerr)
    begin
      pos = 0;
      repeat (6)
        pos = (pos << 1) | int'(lfsr_bit());
      if (!flips[pos])
      begin
        flips[pos] = 1'b1;
        flipped++;
      end
    end
    word    = lane_words[lane] ^ flips;
    hit_cnt = 0;
    watch   = 1'b1;
    repeat (noise)
      send_bit(lfsr_bit());
    for (int k = bt_air_pkg::SYNC_BITS - 1; k >= 0; k--)
      send_bit(word[k]);
    repeat (2 * bt_air_pkg::TICKS_PER_US)
      step();
    watch = 1'b0;
    if (exp_lane < 0 && hit_cnt != 0)
    begin
      $display("stream %0d gave a sync hit where none was expected", idx);
      proto_errs++;
    end
    else if (exp_lane >= 0 && hit_cnt == 0)
    begin
      $display("stream %0d gave no sync hit, lane %0d expected", idx, exp_lane);
      proto_errs++;
    end
    else if (exp_lane >= 0)
    begin
      if (hit_cnt > 1)
      begin
        $display("stream %0d gave %0d sync hits instead of one", idx, hit_cnt);
        proto_errs++;
      end
      check_lane(hit_lane, bt_air_pkg::lane_id_t'(exp_lane), $sformatf("stream %0d", idx));
    end
  endtask

  task automatic load_tests();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    int    d;
    int    bits;
    int    accesses;
    string line;
    string rest;
    bits     = 0;
    accesses = 0;
    fd = $fopen("bt_corr_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open bt_corr_tests.txt");
      proto_errs++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n    = $fgets(line, fd);
        rest = (line.len() > 1) ? line.substr(1, line.len() - 1) : "";
        d    = -1;
        case (line.getc(0))
          "W", "R": n = $sscanf(rest, "%h %h", a, b);
          "S":      n = $sscanf(rest, "%d %d %d %d", a, b, c, d);
          "C":      n = $sscanf(rest, "%d", a);
          default:  n = 0;
        endcase
        if (n > 0)
        begin
          op_q.push_back(line.getc(0));
          a_q.push_back(a);
          b_q.push_back(b);
          c_q.push_back(c);
          d_q.push_back(d);
          if (line.getc(0) == "S")
            bits += a + bt_air_pkg::SYNC_BITS + 3;
          else
            accesses++;
        end
      end
      $fclose(fd);
    end
    cycle_limit = (bits + accesses) * bt_air_pkg::TICKS_PER_US + 500;
  endtask

  initial
  begin
    bt_reg_pkg::wb_data_t rdata;
    logic                 acked;
    clk_6M     = 1'b0;
    rstz       = 1'b0;
    rxbit      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    lfsr_state = 32'h636c;
    value_errs = 0;
    proto_errs = 0;
    watch      = 1'b0;
    hit_cnt    = 0;
    hit_lane   = '0;
    for (int n = 0; n < bt_air_pkg::NUM_LANES; n++)
      lane_words[n] = '0;
    load_tests();
    repeat (2) @(posedge clk_6M);
    rstz <= 1'b1;
    edge_cnt = 0;
    for (int i = 0; i < op_q.size(); i++)
    begin
      case (op_q[i])
        "W":
        begin
          bus_access(1'b1, bt_reg_pkg::wb_adr_t'(a_q[i]), bt_reg_pkg::wb_data_t'(b_q[i]),
                     rdata, acked);
          // keep a copy of the reference words for the streams
          if (a_q[i] < 2 * bt_air_pkg::NUM_LANES)
            lane_words[a_q[i] / 2][32 * (a_q[i] % 2) +: 32] = b_q[i];
        end
        "R":
        begin
          bus_access(1'b0, bt_reg_pkg::wb_adr_t'(a_q[i]), '0, rdata, acked);
          if (acked)
            check_data(rdata, bt_reg_pkg::wb_data_t'(b_q[i]),
                       $sformatf("read of address %0d", a_q[i]));
        end
        "S": run_stream(i, a_q[i], b_q[i], c_q[i], d_q[i]);
        default:
        begin
          step();
          check_count(count_seen, bt_air_pkg::hit_cnt_t'(a_q[i]), "sync_count");
        end
      endcase
    end
    $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    int cycles;
    cycles = 0;
    @(posedge rstz);
    while (cycles < cycle_limit)
    begin
      @(posedge clk_6M);
      cycles++;
    end
    $display("timeout after %0d clock cycles, the tests did not finish", cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule
